//--- hdl/core_pkg.sv
package core_pkg;

    // ****************************************
    // memory operation of an instruction
    // ****************************************
    typedef enum logic [3:0] {
        op_none    = 4'd0,
        op_lb      = 4'd1,
        op_lbu     = 4'd2,
        op_lh      = 4'd3,
        op_lhu     = 4'd4,
        op_lw      = 4'd5,
        op_sb      = 4'd6,
        op_sh      = 4'd7,
        op_sw      = 4'd8,
        op_amoswap = 4'd9
    } mem_op_e;

    // control bundle, 36 bits
    typedef struct packed {
        mem_op_e     mem_op;
        logic [31:0] rs2_data;
    } ctrl_t;

    // ****************************************
    // stage bundles
    // ****************************************

    // from execute, 228 bits
    typedef struct packed {
        logic [31:0] reg_pc;
        logic [31:0] inst;
        logic [63:0] inst_id;
        ctrl_t       ctrl;
        logic [31:0] alu_out;
        logic [31:0] csr_rdata;
    } stage_in_t;

    // toward write-back, 260 bits
    typedef struct packed {
        logic [31:0] reg_pc;
        logic [31:0] inst;
        logic [63:0] inst_id;
        ctrl_t       ctrl;
        logic [31:0] alu_out;
        logic [31:0] csr_rdata;
        logic [31:0] mem_rdata;
    } wb_t;

    function automatic logic is_mem_op(mem_op_e op);
        return op != op_none;
    endfunction

    // amoswap is not a store until its read has finished
    function automatic logic is_store_op(mem_op_e op);
        return op inside {op_sb, op_sh, op_sw};
    endfunction

endpackage

//--- hdl/memif_pkg.sv
package memif_pkg;

    // ****************************************
    // command from the stage to the unit
    // ****************************************

    // 97 bits; wdata and wmask sit in the low lanes
    typedef struct packed {
        logic        write;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] wmask;
    } mem_cmd_t;

    // ****************************************
    // default sizes
    // ****************************************

    // cycles from accept to completion
    localparam int default_latency = 2;

    // depth in 32-bit words, power of two
    localparam int default_ram_words = 1024;

endpackage

//--- hdl/data_ram.sv
`timescale 1ns/10ps

module data_ram #(
    parameter int ram_words = memif_pkg::default_ram_words
) (
    input  logic                         clk,
    input  logic                         we,
    input  logic [$clog2(ram_words)-1:0] addr,
    input  logic [31:0]                  wdata,
    input  logic [31:0]                  wmask,
    output logic [31:0]                  rdata
);

    logic [31:0] mem [ram_words];

    // ****************************************
    // write port, bit-masked
    // ****************************************
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= (mem[addr] & ~wmask) | (wdata & wmask);
        end
    end

    // registered read, old data on a same-cycle write
    always_ff @(posedge clk) begin
        rdata <= mem[addr];
    end

endmodule

//--- hdl/memory_unit.sv
`timescale 1ns/10ps

module memory_unit #(
    parameter int mem_latency = memif_pkg::default_latency,
    parameter int ram_words   = memif_pkg::default_ram_words
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         cmd_start,
    input  memif_pkg::mem_cmd_t          cmd,
    input  logic [31:0]                  ram_rdata,
    output logic                         cmd_ready,
    output logic                         rsp_valid,
    output logic [31:0]                  rsp_rdata,
    output logic                         ram_we,
    output logic [$clog2(ram_words)-1:0] ram_addr,
    output logic [31:0]                  ram_wdata,
    output logic [31:0]                  ram_wmask
);

    localparam int addr_w = $clog2(ram_words);
    localparam int cnt_w  = $clog2(mem_latency + 1);

    logic [cnt_w-1:0]  busy_cnt;
    logic              read_q;
    logic [1:0]        off_q;
    logic [addr_w-1:0] addr_q;

    logic              accept;
    logic [addr_w-1:0] cmd_word;
    logic [4:0]        cmd_shift;

    assign accept    = cmd_start && cmd_ready;
    assign cmd_ready = busy_cnt == '0;

    // upper address bits drop off, so the RAM wraps
    assign cmd_word  = cmd.addr[addr_w+1:2];
    assign cmd_shift = {cmd.addr[1:0], 3'b000};

    // ****************************************
    // latency counter
    // ****************************************
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_cnt <= '0;
            read_q   <= 1'b0;
        end else if (accept) begin
            busy_cnt <= cnt_w'(mem_latency);
            read_q   <= !cmd.write;
        end else if (busy_cnt != '0) begin
            busy_cnt <= busy_cnt - 1'b1;
        end
    end

    // lane offset and word index of the command in flight
    always_ff @(posedge clk) begin
        if (accept) begin
            off_q  <= cmd.addr[1:0];
            addr_q <= cmd_word;
        end
    end

    // ****************************************
    // RAM side
    // ****************************************

    // held address keeps the registered read pointing at the same word
    assign ram_addr  = accept ? cmd_word : addr_q;
    assign ram_we    = accept && cmd.write;
    assign ram_wdata = cmd.wdata << cmd_shift;
    assign ram_wmask = cmd.wmask << cmd_shift;

    // response in the last busy cycle
    assign rsp_valid = read_q && (busy_cnt == cnt_w'(1));
    assign rsp_rdata = ram_rdata >> {off_q, 3'b000};

    // ready stays low for exactly the access latency
    a_no_accept_while_busy: assert property (
        @(posedge clk) disable iff (!rst_n)
        accept |=> (!cmd_ready) [*mem_latency] ##1 cmd_ready
    );

endmodule

//--- hdl/memory_stage.sv
`timescale 1ns/10ps

module memory_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                mem_valid,
    input  core_pkg::stage_in_t mem_in,
    input  logic                pipeline_flush,
    input  logic                cmd_ready,
    input  logic                rsp_valid,
    input  logic [31:0]         rsp_rdata,
    output logic                wb_valid,
    output core_pkg::wb_t       wb,
    output logic                memory_unit_stall,
    output logic                cmd_start,
    output memif_pkg::mem_cmd_t cmd
);

    import core_pkg::*;

    typedef enum logic [1:0] {
        st_wait,
        st_wait_ready,
        st_wait_read_valid
    } state_e;

    state_e      state;
    logic        executed;
    logic [63:0] saved_inst_id;
    mem_op_e     op_override;
    logic [31:0] rdata_q;
    logic        orphan_rsp;

    logic        new_inst;
    logic        armed;
    mem_op_e     cur_op;
    logic        cur_store;
    logic        accept;
    logic        read_done;

    function automatic logic [31:0] extend_load(mem_op_e op, logic [31:0] word);
        case (op)
            op_lb:   return {{24{word[7]}}, word[7:0]};
            op_lbu:  return {24'h000000, word[7:0]};
            op_lh:   return {{16{word[15]}}, word[15:0]};
            op_lhu:  return {16'h0000, word[15:0]};
            // lw and amoswap keep the whole word
            default: return word;
        endcase
    endfunction

    // ****************************************
    // access tracking
    // ****************************************

    // a changed id means a fresh instruction
    assign new_inst = saved_inst_id != mem_in.inst_id;
    assign armed    = !executed || new_inst;

    // amoswap turns into sw after its read
    assign cur_op    = (state == st_wait) ? mem_in.ctrl.mem_op : op_override;
    assign cur_store = is_store_op(cur_op);
    assign accept    = cmd_start && cmd_ready;

    assign read_done = (state == st_wait_read_valid) && rsp_valid && mem_valid &&
                       !pipeline_flush;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state         <= st_wait;
            executed      <= 1'b0;
            op_override   <= op_none;
            saved_inst_id <= '0;
        end else begin
            saved_inst_id <= mem_in.inst_id;
            if (new_inst) begin
                executed <= 1'b0;
            end
            if (pipeline_flush || !mem_valid) begin
                state       <= st_wait;
                op_override <= op_none;
            end else begin
                case (state)
                    st_wait: begin
                        if (armed && is_mem_op(mem_in.ctrl.mem_op)) begin
                            state       <= st_wait_ready;
                            op_override <= mem_in.ctrl.mem_op;
                        end
                    end
                    st_wait_ready: begin
                        if (accept && cur_store) begin
                            state       <= st_wait;
                            executed    <= 1'b1;
                            op_override <= op_none;
                        end else if (accept) begin
                            state <= st_wait_read_valid;
                        end
                    end
                    st_wait_read_valid: begin
                        if (rsp_valid && cur_op == op_amoswap) begin
                            // write back rs2_data over the word just read
                            state       <= st_wait_ready;
                            op_override <= op_sw;
                        end else if (rsp_valid) begin
                            state       <= st_wait;
                            executed    <= 1'b1;
                            op_override <= op_none;
                        end
                    end
                    default: state <= st_wait;
                endcase
            end
        end
    end

    // amoswap keeps the old word, the later store leaves this alone
    always_ff @(posedge clk) begin
        if (read_done) begin
            rdata_q <= rsp_rdata;
        end
    end

    // read abandoned by a flush, its response still to come
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            orphan_rsp <= 1'b0;
        end else if (rsp_valid) begin
            orphan_rsp <= 1'b0;
        end else if (state == st_wait_read_valid && (pipeline_flush || !mem_valid)) begin
            orphan_rsp <= 1'b1;
        end
    end

    // ****************************************
    // command and outputs
    // ****************************************
    assign cmd_start = (state == st_wait_ready) && mem_valid && !pipeline_flush;

    assign cmd = '{
        write: cur_store,
        addr:  mem_in.alu_out,
        wdata: mem_in.ctrl.rs2_data,
        wmask: (cur_op == op_sb) ? 32'h0000_00ff :
               (cur_op == op_sh) ? 32'h0000_ffff : 32'hffff_ffff
    };

    assign memory_unit_stall = (state != st_wait) ||
                               (mem_valid && armed && is_mem_op(mem_in.ctrl.mem_op));

    assign wb_valid = mem_valid && !pipeline_flush && !memory_unit_stall;

    assign wb = '{
        reg_pc:    mem_in.reg_pc,
        inst:      mem_in.inst,
        inst_id:   mem_in.inst_id,
        ctrl:      mem_in.ctrl,
        alu_out:   mem_in.alu_out,
        csr_rdata: mem_in.csr_rdata,
        mem_rdata: extend_load(mem_in.ctrl.mem_op, rdata_q)
    };

    // ****************************************
    // assertions
    // ****************************************

    // first cycle of a new instruction is its wait cycle, no command yet
    a_no_start_in_wait: assert property (
        @(posedge clk) disable iff (!rst_n)
        new_inst |-> !cmd_start
    );

    // a response outside the read wait must belong to a flushed read
    a_rsp_only_when_expected: assert property (
        @(posedge clk) disable iff (!rst_n)
        rsp_valid && state != st_wait_read_valid |-> orphan_rsp
    );

endmodule

//--- hdl/mem_subsys_top.sv
`timescale 1ns/10ps

module mem_subsys_top #(
    parameter int mem_latency = memif_pkg::default_latency,
    parameter int ram_words   = memif_pkg::default_ram_words
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                mem_valid,
    input  core_pkg::stage_in_t mem_in,
    input  logic                pipeline_flush,
    output logic                wb_valid,
    output core_pkg::wb_t       wb,
    output logic                memory_unit_stall
);

    import memif_pkg::*;

    localparam int addr_w = $clog2(ram_words);

    // stage to unit
    logic        cmd_start;
    logic        cmd_ready;
    mem_cmd_t    cmd;
    logic        rsp_valid;
    logic [31:0] rsp_rdata;

    // unit to RAM
    logic              ram_we;
    logic [addr_w-1:0] ram_addr;
    logic [31:0]       ram_wdata;
    logic [31:0]       ram_wmask;
    logic [31:0]       ram_rdata;

    memory_stage i_memory_stage (
        .clk               (clk),
        .rst_n             (rst_n),
        .mem_valid         (mem_valid),
        .mem_in            (mem_in),
        .pipeline_flush    (pipeline_flush),
        .cmd_ready         (cmd_ready),
        .rsp_valid         (rsp_valid),
        .rsp_rdata         (rsp_rdata),
        .wb_valid          (wb_valid),
        .wb                (wb),
        .memory_unit_stall (memory_unit_stall),
        .cmd_start         (cmd_start),
        .cmd               (cmd)
    );

    memory_unit #(
        .mem_latency (mem_latency),
        .ram_words   (ram_words)
    ) i_memory_unit (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_start (cmd_start),
        .cmd       (cmd),
        .ram_rdata (ram_rdata),
        .cmd_ready (cmd_ready),
        .rsp_valid (rsp_valid),
        .rsp_rdata (rsp_rdata),
        .ram_we    (ram_we),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .ram_wmask (ram_wmask)
    );

    data_ram #(
        .ram_words (ram_words)
    ) i_data_ram (
        .clk   (clk),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .wmask (ram_wmask),
        .rdata (ram_rdata)
    );

endmodule

//--- include/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// ****************************************
// error counters
// ****************************************
int err_wb      = 0;
int err_word    = 0;
int err_timeout = 0;

task automatic check_wb(input string tag, input core_pkg::wb_t got,
                        input core_pkg::wb_t exp);
    if (got !== exp) begin
        err_wb++;
        $display("[FAIL] %s at %0t: got %h exp %h", tag, $time, got, exp);
    end
endtask

task automatic check_word(input string tag, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
        err_word++;
        $display("[FAIL] %s at %0t: got %h exp %h", tag, $time, got, exp);
    end
endtask

// ****************************************
// waits, bounded by a cycle count
// ****************************************
task automatic wait_stall_low(input string tag, input int max_cycles);
    int n;
    n = 0;
    while (i_dut.memory_unit_stall !== 1'b0) begin
        if (n == max_cycles) begin
            err_timeout++;
            $display("[%0t] %s: stall stuck high", $time, tag);
            return;
        end
        @(posedge clk);
        #1;
        n++;
    end
endtask

`endif

//--- bench/tb_mem_subsys.sv
`timescale 1ns/10ps

module tb_mem_subsys;

    import core_pkg::*;

    logic      clk;
    logic      rst_n;
    logic      mem_valid;
    stage_in_t mem_in;
    logic      pipeline_flush;
    logic      wb_valid;
    wb_t       wb;
    logic      memory_unit_stall;

    // reference model of the first 64 RAM words
    logic [31:0] shadow [64];
    logic [63:0] next_id;
    int          seed;

    `include "tb_checks.svh"

    mem_subsys_top i_dut (
        .clk               (clk),
        .rst_n             (rst_n),
        .mem_valid         (mem_valid),
        .mem_in            (mem_in),
        .pipeline_flush    (pipeline_flush),
        .wb_valid          (wb_valid),
        .wb                (wb),
        .memory_unit_stall (memory_unit_stall)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ****************************************
    // reference rules
    // ****************************************
    function automatic logic [31:0] load_value(mem_op_e op, logic [31:0] word, logic [1:0] off);
        logic [7:0]  b;
        logic [15:0] h;
        b = 8'(word >> (8 * off));
        h = off[1] ? word[31:16] : word[15:0];
        case (op)
            op_lb:   return 32'($signed(b));
            op_lbu:  return 32'(b);
            op_lh:   return 32'($signed(h));
            op_lhu:  return 32'(h);
            default: return word;
        endcase
    endfunction

    function automatic logic [31:0] merge_store(mem_op_e op, logic [31:0] word,
                                                logic [1:0] off, logic [31:0] data);
        logic [31:0] res;
        res = word;
        case (op)
            op_sb:   res[8 * off +: 8] = data[7:0];
            op_sh:   res[16 * off[1] +: 16] = data[15:0];
            default: res = data;
        endcase
        return res;
    endfunction

    function automatic stage_in_t make_inst(mem_op_e op, logic [31:0] addr, logic [31:0] data);
        stage_in_t s;
        s.reg_pc        = $random(seed);
        s.inst          = $random(seed);
        s.inst_id       = next_id;
        s.ctrl.mem_op   = op;
        s.ctrl.rs2_data = data;
        s.alu_out       = addr;
        s.csr_rdata     = $random(seed);
        next_id         = next_id + 64'd1;
        return s;
    endfunction

    // present one instruction, wait for stall to drop, check write-back
    task automatic exec_op(input mem_op_e op, input logic [31:0] addr, input logic [31:0] data);
        stage_in_t  s;
        wb_t        exp;
        wb_t        got;
        logic [5:0] w;
        s   = make_inst(op, addr, data);
        w   = addr[7:2];
        exp = {s, 32'h0};
        @(posedge clk);
        mem_in    <= s;
        mem_valid <= 1'b1;
        #1;
        wait_stall_low("exec_op", 40);
        check_word("wb_valid", 32'(wb_valid), 32'd1);
        got = wb;
        if (op inside {op_lb, op_lbu, op_lh, op_lhu, op_lw, op_amoswap}) begin
            exp.mem_rdata = load_value(op, shadow[w], addr[1:0]);
        end else begin
            // no load data defined for stores or plain instructions
            got.mem_rdata = 32'h0;
        end
        check_wb("wb", got, exp);
        if (op inside {op_sb, op_sh, op_sw, op_amoswap}) begin
            shadow[w] = merge_store(op, shadow[w], addr[1:0], data);
        end
    endtask

    // ****************************************
    // directed tests
    // ****************************************
    task automatic fill_memory();
        logic [31:0] a;
        for (int i = 0; i < 64; i++) begin
            a = 32'(i * 4);
            exec_op(op_sw, a, {~a[15:0], a[15:0] ^ 16'h5a3c});
        end
    endtask

    task automatic test_word_and_swap();
        exec_op(op_sw, 32'h40, 32'hdead_beef);
        exec_op(op_lw, 32'h40, '0);
        exec_op(op_amoswap, 32'h40, 32'h0bad_cafe);
        exec_op(op_lw, 32'h40, '0);
    endtask

    task automatic test_subword();
        for (int off = 0; off < 4; off++) begin
            exec_op(op_sb, 32'h80 + off, 32'h0000_0080 + 32'(off) * 32'h11);
            exec_op(op_lb, 32'h80 + off, '0);
            exec_op(op_lbu, 32'h80 + off, '0);
        end
        exec_op(op_lw, 32'h80, '0);
        for (int off = 0; off < 4; off += 2) begin
            exec_op(op_sh, 32'h90 + off, (off == 0) ? 32'h1234_8765 : 32'h5678_4321);
            exec_op(op_lh, 32'h90 + off, '0);
            exec_op(op_lhu, 32'h90 + off, '0);
        end
        exec_op(op_lw, 32'h90, '0);
    endtask

    task automatic test_passthrough();
        stage_in_t s;
        wb_t       got;
        s = make_inst(op_none, 32'h1234_5678, 32'h0);
        @(posedge clk);
        mem_in    <= s;
        mem_valid <= 1'b1;
        #1;
        // result is due in the cycle the instruction shows up
        check_word("wb_valid", 32'(wb_valid), 32'd1);
        check_word("memory_unit_stall", 32'(memory_unit_stall), 32'd0);
        got           = wb;
        got.mem_rdata = 32'h0;
        check_wb("wb", got, {s, 32'h0});
        // same op twice, distinct ids
        exec_op(op_sw, 32'hc0, 32'h1111_2222);
        exec_op(op_sw, 32'hc4, 32'h3333_4444);
        exec_op(op_lw, 32'hc0, '0);
        exec_op(op_lw, 32'hc4, '0);
    endtask

    task automatic test_flush();
        @(posedge clk);
        mem_in         <= make_inst(op_sw, 32'hd0, 32'hffff_0000);
        mem_valid      <= 1'b1;
        pipeline_flush <= 1'b1;
        repeat (3) begin
            #1;
            check_word("wb_valid", 32'(wb_valid), 32'd0);
            @(posedge clk);
        end
        // a plain instruction would otherwise pass straight through
        mem_in <= make_inst(op_none, 32'h0000_0d00, 32'h0);
        #1;
        check_word("wb_valid", 32'(wb_valid), 32'd0);
        @(posedge clk);
        pipeline_flush <= 1'b0;
        mem_valid      <= 1'b0;
        exec_op(op_lw, 32'hd0, '0);
    endtask

    task automatic random_mix(input int count);
        logic [31:0] r;
        logic [31:0] addr;
        mem_op_e     op;
        for (int i = 0; i < count; i++) begin
            r    = $random(seed);
            op   = mem_op_e'(4'(r[3:0] % 9 + 1));
            addr = {24'h0, r[13:8], 2'b00};
            if (op inside {op_sb, op_lb, op_lbu}) begin
                addr[1:0] = r[17:16];
            end else if (op inside {op_sh, op_lh, op_lhu}) begin
                addr[1] = r[17];
            end
            exec_op(op, addr, $random(seed));
        end
    endtask

    initial begin
        seed           = 92;
        next_id        = 64'd1;
        rst_n          = 1'b0;
        mem_valid      = 1'b0;
        mem_in         = '0;
        pipeline_flush = 1'b0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        fill_memory();
        test_word_and_swap();
        test_subword();
        test_passthrough();
        test_flush();
        random_mix(200);
        @(posedge clk);
        mem_valid <= 1'b0;
        $display("errors: wb %0d, word %0d, timeout %0d", err_wb, err_word, err_timeout);
        if (err_wb + err_word + err_timeout == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- src.f
+incdir+include
hdl/core_pkg.sv
hdl/memif_pkg.sv
hdl/data_ram.sv
hdl/memory_unit.sv
hdl/memory_stage.sv
hdl/mem_subsys_top.sv
bench/tb_mem_subsys.sv

//--- Makefile
SIM  := obj_dir/Vtb_mem_subsys
SRCS := src.f $(wildcard hdl/*.sv bench/*.sv include/*.svh)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_mem_subsys \
		-f src.f -o Vtb_mem_subsys

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir
